// ==== sim.f ====
+incdir+design
design/tlp_mon_pkg.sv
design/tlp_hdr_decode.sv
design/read_event_tracker.sv
design/counter_readout.sv
design/tlp_read_monitor.sv
tb/tlp_read_monitor_tb.sv

// ==== Makefile ====
# Verilator build and run for the TLP read monitor testbench

SRCS = sim.f \
       design/tlp_mon_defs.svh \
       design/tlp_mon_pkg.sv \
       design/tlp_hdr_decode.sv \
       design/read_event_tracker.sv \
       design/counter_readout.sv \
       design/tlp_read_monitor.sv \
       tb/tlp_read_monitor_tb.sv

.PHONY: all run clean

all: run

obj_dir/Vtlp_read_monitor_tb: $(SRCS)
	verilator --binary --timescale 1ns/1ns -f sim.f \
		--top-module tlp_read_monitor_tb -Mdir obj_dir -o Vtlp_read_monitor_tb

run: obj_dir/Vtlp_read_monitor_tb
	./obj_dir/Vtlp_read_monitor_tb | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/tlp_read_monitor_tb.sv ====
/*
 * Testbench for the TLP read monitor
 * Random traffic on the three streams, checked against a counter model
 * through the four-phase readout port
 */

`timescale 1ns/1ns
`default_nettype none

`include "tlp_mon_defs.svh"

module tlp_read_monitor_tb;

    localparam int TRAFFIC_CYCLES = 300;
    localparam int NUM_PHASES     = 5;
    localparam int NUM_READS      = 60;
    localparam int READ_CYCLES    = 16;
    localparam int HS_LIMIT       = 8;
    localparam int TEST_CYCLES    = 20 + NUM_PHASES * (TRAFFIC_CYCLES + 6)
                                    + NUM_READS * READ_CYCLES;
    localparam int WATCHDOG_NS    = TEST_CYCLES * 10 + 1000;

    logic                      clk;
    logic                      reset_n;
    logic                      en_tx;
    logic                      en_tx_b;
    logic                      en_rx;
    logic [`TLP_DATA_W-1:0]    tx_data;
    logic [`TLP_DATA_W-1:0]    tx_b_data;
    logic [`TLP_DATA_W-1:0]    rx_data;
    logic                      tx_tlast;
    logic                      tx_b_tlast;
    logic                      rx_tlast;
    logic                      cfg_req;
    tlp_mon_pkg::counter_sel_t cfg_sel;
    tlp_mon_pkg::readout_op_t  cfg_op;
    logic                      cfg_ack;
    logic [`CNT_W-1:0]         cfg_data;

    integer seed = 32'h9f69_70e3;
    int     errors = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;

    // Reference model indexed by counter select
    logic [`CNT_W-1:0] m_cnt [5];
    logic              model_sop [3];
    int                beats_left [3];

    tlp_read_monitor tlp_read_monitor_inst
        (.clk, .reset_n, .en_tx, .tx_data, .tx_tlast, .en_tx_b, .tx_b_data, .tx_b_tlast,
         .en_rx, .rx_data, .rx_tlast, .cfg_req, .cfg_sel, .cfg_op, .cfg_ack, .cfg_data);

    always #5 clk = ~clk;

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run did not complete in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic string counter_name(input int sel);
        case (sel)
            0:       return "req_dwords";
            1:       return "rsp_dwords";
            2:       return "outstanding";
            3:       return "req_tlps";
            default: return "cpl_tlps";
        endcase
    endfunction

    function automatic logic [`TLP_DATA_W-1:0] random_vector();
        logic [`TLP_DATA_W-1:0] v;
        for (int k = 0; k < `TLP_DATA_W / 32; k++)
            v[k*32 +: 32] = $random(seed);
        return v;
    endfunction

    // Mode 1 favours reads on tx and mode 2 favours completions on rx
    function automatic logic [7:0] pick_fmt(input int s, input int mode);
        int r;
        r = $random(seed) & 7;
        if (mode == 1 && s < 2 && r < 4)
            return (r < 2) ? 8'h00 : 8'h20;
        if (mode == 2 && s == 2 && r < 4)
            return (r < 2) ? 8'h0A : 8'h4A;
        r = $random(seed) & 7;
        case (r)
            0:       return 8'h00;
            1:       return 8'h20;
            2:       return 8'h40;
            3:       return 8'h60;
            4:       return 8'h0A;
            5:       return 8'h4A;
            default: return 8'($random(seed));
        endcase
    endfunction

    task automatic make_beat(input int s, input int mode, output logic en,
                             output logic [`TLP_DATA_W-1:0] data, output logic last);
        int n;
        en   = ($random(seed) & 3) != 0;
        data = random_vector();
        last = ($random(seed) & 1) != 0;
        if (en)
        begin
            if (beats_left[s] == 0)
            begin
                n = 1 + ($random(seed) & 3);
                if (mode == 3 && n == 1)
                    n = 3;
                data[31:24] = pick_fmt(s, mode);
                if (($random(seed) & 7) == 0)
                    data[9:0] = '0;
                beats_left[s] = n;
            end
            else if (mode == 3 || ($random(seed) & 3) == 0)
                data[31:24] = (s == 2) ? 8'h4A : 8'h00;   // payload posing as a header
            beats_left[s] = beats_left[s] - 1;
            last = (beats_left[s] == 0);
        end
    endtask

    task automatic model_beat(input int s, input logic en,
                              input logic [`TLP_DATA_W-1:0] data, input logic last);
        logic [7:0]        fmt;
        logic              is_mrd;
        logic              is_cpl;
        logic              is_cpld;
        logic [`CNT_W-1:0] len;
        if (en && model_sop[s])
        begin
            // MRd is 00 or 20, Cpl is 0A and CplD is 4A
            fmt     = data[31:24];
            is_mrd  = (fmt == 8'h00) || (fmt == 8'h20);
            is_cpl  = (fmt == 8'h0A);
            is_cpld = (fmt == 8'h4A);
            len     = (data[9:0] == 10'd0) ? `CNT_W'(1024) : `CNT_W'(data[9:0]);
            if (s < 2 && is_mrd)
            begin
                m_cnt[tlp_mon_pkg::SEL_REQ_DWORDS]  += len;
                m_cnt[tlp_mon_pkg::SEL_OUTSTANDING] += len;
                m_cnt[tlp_mon_pkg::SEL_REQ_TLPS]    += 1;
            end
            if (s == 2 && (is_cpl || is_cpld))
                m_cnt[tlp_mon_pkg::SEL_CPL_TLPS] += 1;
            if (s == 2 && is_cpld)
            begin
                m_cnt[tlp_mon_pkg::SEL_RSP_DWORDS]  += len;
                m_cnt[tlp_mon_pkg::SEL_OUTSTANDING] -= len;
            end
        end
        if (en)
            model_sop[s] = last;
    endtask

    task automatic run_traffic(input int mode);
        logic                   en;
        logic [`TLP_DATA_W-1:0] d;
        logic                   last;
        for (int c = 0; c < TRAFFIC_CYCLES; c++)
        begin
            @(posedge clk);
            for (int s = 0; s < 3; s++)
            begin
                make_beat(s, mode, en, d, last);
                model_beat(s, en, d, last);
                case (s)
                    0:
                    begin
                        en_tx    <= en;
                        tx_data  <= d;
                        tx_tlast <= last;
                    end
                    1:
                    begin
                        en_tx_b    <= en;
                        tx_b_data  <= d;
                        tx_b_tlast <= last;
                    end
                    default:
                    begin
                        en_rx    <= en;
                        rx_data  <= d;
                        rx_tlast <= last;
                    end
                endcase
            end
        end
        // Let the two-cycle count pipeline drain before any readout
        @(posedge clk);
        en_tx   <= 1'b0;
        en_tx_b <= 1'b0;
        en_rx   <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic read_counter(input int sel, input tlp_mon_pkg::readout_op_t op);
        int                cycles;
        logic [`CNT_W-1:0] expected;
        expected = m_cnt[sel];
        @(posedge clk);
        cfg_sel <= tlp_mon_pkg::counter_sel_t'(sel);
        cfg_op  <= op;
        cfg_req <= 1'b1;
        @(negedge clk);
        if (cfg_ack)
        begin
            $display("Readout of %s: ack high before the request was sampled",
                     counter_name(sel));
            errors++;
        end
        cycles = 0;
        while (!cfg_ack && cycles < HS_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!cfg_ack)
        begin
            $display("Readout of %s: no ack within %0d cycles", counter_name(sel), HS_LIMIT);
            errors++;
            @(posedge clk);
            cfg_req <= 1'b0;
            return;
        end
        if (cfg_data !== expected)
        begin
            $display("[ERROR] t=%0t %s expected=0x%08h actual=0x%08h",
                     $time, counter_name(sel), expected, cfg_data);
            errors++;
        end
        if (op == tlp_mon_pkg::OP_READ_CLEAR)
            m_cnt[sel] = '0;
        @(posedge clk);
        cfg_req <= 1'b0;
        @(negedge clk);
        if (!cfg_ack)
        begin
            $display("Readout of %s: ack dropped before the request fell", counter_name(sel));
            errors++;
        end
        cycles = 0;
        while (cfg_ack && cycles < HS_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (cfg_ack)
        begin
            $display("Readout of %s: ack stayed high after the request fell",
                     counter_name(sel));
            errors++;
        end
    endtask

    task automatic read_all();
        for (int i = 0; i < 5; i++)
            read_counter(i, tlp_mon_pkg::OP_READ);
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (errors == err_before)
        begin
            tests_passed++;
            $display("PASS  %s", name);
        end
        else
        begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", name, errors - err_before);
        end
    endtask

    initial
    begin
        int err_before;
        clk        = 1'b0;
        reset_n    = 1'b0;
        en_tx      = 1'b0;
        en_tx_b    = 1'b0;
        en_rx      = 1'b0;
        tx_data    = '0;
        tx_b_data  = '0;
        rx_data    = '0;
        tx_tlast   = 1'b0;
        tx_b_tlast = 1'b0;
        rx_tlast   = 1'b0;
        cfg_req    = 1'b0;
        cfg_sel    = tlp_mon_pkg::SEL_REQ_DWORDS;
        cfg_op     = tlp_mon_pkg::OP_READ;
        for (int i = 0; i < 5; i++)
            m_cnt[i] = '0;
        for (int s = 0; s < 3; s++)
        begin
            model_sop[s]  = 1'b1;
            beats_left[s] = 0;
        end

        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        repeat (2) @(posedge clk);

        err_before = errors;
        @(negedge clk);
        if (cfg_ack)
        begin
            $display("cfg_ack is high after reset");
            errors++;
        end
        read_all();
        finish_test("reset state", err_before);

        err_before = errors;
        run_traffic(1);
        read_all();
        finish_test("request dword totals", err_before);

        err_before = errors;
        run_traffic(2);
        read_all();
        finish_test("completion totals", err_before);

        err_before = errors;
        run_traffic(3);
        read_all();
        finish_test("header-only decoding", err_before);

        err_before = errors;
        run_traffic(0);
        read_all();
        finish_test("outstanding count", err_before);

        // Clear each counter in turn while the others hold their values
        err_before = errors;
        run_traffic(0);
        for (int i = 0; i < 5; i++)
        begin
            read_counter(i, tlp_mon_pkg::OP_READ_CLEAR);
            read_counter(i, tlp_mon_pkg::OP_READ);
            for (int j = 0; j < 5; j++)
                if (j != i)
                    read_counter(j, tlp_mon_pkg::OP_READ);
        end
        finish_test("handshake and clear", err_before);

        $display("Tests run: %0d, passed: %0d, failed: %0d, check errors: %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/tlp_read_monitor.sv ====
/*
 * PCIe TLP read traffic monitor, top level
 * Three stream decoders feed the event tracker, read via a req/ack port
 */

`timescale 1ns/1ns
`default_nettype none

`include "tlp_mon_defs.svh"

module tlp_read_monitor
(
    input  wire                              clk,
    input  wire                              reset_n,

    input  wire                              en_tx,
    input  wire  [`TLP_DATA_W-1:0]           tx_data,
    input  wire                              tx_tlast,

    input  wire                              en_tx_b,
    input  wire  [`TLP_DATA_W-1:0]           tx_b_data,
    input  wire                              tx_b_tlast,

    input  wire                              en_rx,
    input  wire  [`TLP_DATA_W-1:0]           rx_data,
    input  wire                              rx_tlast,

    input  wire                              cfg_req,
    input  wire  tlp_mon_pkg::counter_sel_t  cfg_sel,
    input  wire  tlp_mon_pkg::readout_op_t   cfg_op,
    output logic                             cfg_ack,
    output logic [`CNT_W-1:0]                cfg_data
);

    logic [`DWORD_CNT_W-1:0]   tx_dwords, tx_b_dwords, rx_dwords;
    logic                      tx_event, tx_b_event, rx_event;
    logic [`CNT_W-1:0]         req_dwords, rsp_dwords, outstanding, req_tlps, cpl_tlps;
    logic                      clear;
    tlp_mon_pkg::counter_sel_t clear_sel;

    // Request pipes count MRd, the completion pipe counts Cpl and CplD
    tlp_hdr_decode #(.IS_COMPLETION(0)) tx_dec
        (.clk, .reset_n, .en(en_tx), .data(tx_data), .tlast(tx_tlast),
         .rd_dwords(tx_dwords), .tlp_event(tx_event));

    tlp_hdr_decode #(.IS_COMPLETION(0)) tx_b_dec
        (.clk, .reset_n, .en(en_tx_b), .data(tx_b_data), .tlast(tx_b_tlast),
         .rd_dwords(tx_b_dwords), .tlp_event(tx_b_event));

    tlp_hdr_decode #(.IS_COMPLETION(1)) rx_dec
        (.clk, .reset_n, .en(en_rx), .data(rx_data), .tlast(rx_tlast),
         .rd_dwords(rx_dwords), .tlp_event(rx_event));

    read_event_tracker tracker
        (.clk, .reset_n, .tx_dwords, .tx_b_dwords, .rx_dwords,
         .tx_event, .tx_b_event, .rx_event, .clear, .clear_sel,
         .req_dwords, .rsp_dwords, .outstanding, .req_tlps, .cpl_tlps);

    counter_readout readout
        (.clk, .reset_n, .cfg_req, .cfg_sel, .cfg_op,
         .req_dwords, .rsp_dwords, .outstanding, .req_tlps, .cpl_tlps,
         .cfg_ack, .cfg_data, .clear, .clear_sel);

endmodule

`default_nettype wire

// ==== design/counter_readout.sv ====
/*
 * Counter readout port
 * Four-phase req/ack access that snapshots a selected counter
 * and optionally clears it in the tracker
 */

`timescale 1ns/1ns
`default_nettype none

`include "tlp_mon_defs.svh"

module counter_readout
(
    input  wire                              clk,
    input  wire                              reset_n,

    input  wire                              cfg_req,
    input  wire  tlp_mon_pkg::counter_sel_t  cfg_sel,
    input  wire  tlp_mon_pkg::readout_op_t   cfg_op,

    input  wire  [`CNT_W-1:0]                req_dwords,
    input  wire  [`CNT_W-1:0]                rsp_dwords,
    input  wire  [`CNT_W-1:0]                outstanding,
    input  wire  [`CNT_W-1:0]                req_tlps,
    input  wire  [`CNT_W-1:0]                cpl_tlps,

    output logic                             cfg_ack,
    output logic [`CNT_W-1:0]                cfg_data,
    output logic                             clear,
    output tlp_mon_pkg::counter_sel_t        clear_sel
);

    tlp_mon_pkg::readout_state_t state;
    logic [`CNT_W-1:0]           sel_value;
    logic                        accept;

    always_comb
    begin
        case (cfg_sel)
            tlp_mon_pkg::SEL_REQ_DWORDS:  sel_value = req_dwords;
            tlp_mon_pkg::SEL_RSP_DWORDS:  sel_value = rsp_dwords;
            tlp_mon_pkg::SEL_OUTSTANDING: sel_value = outstanding;
            tlp_mon_pkg::SEL_REQ_TLPS:    sel_value = req_tlps;
            tlp_mon_pkg::SEL_CPL_TLPS:    sel_value = cpl_tlps;
            default:                      sel_value = '0;
        endcase
    end

    // New request seen while idle, counter is sampled on this edge
    assign accept    = (state == tlp_mon_pkg::RD_IDLE) && cfg_req;
    assign clear     = accept && (cfg_op == tlp_mon_pkg::OP_READ_CLEAR);
    assign clear_sel = cfg_sel;
    assign cfg_ack   = (state == tlp_mon_pkg::RD_ACK);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= tlp_mon_pkg::RD_IDLE;
        else
        begin
            case (state)
                tlp_mon_pkg::RD_IDLE:
                    if (cfg_req)
                        state <= tlp_mon_pkg::RD_ACK;
                tlp_mon_pkg::RD_ACK:
                    if (!cfg_req)
                        state <= tlp_mon_pkg::RD_WAIT_DROP;
                // One turnaround cycle with ack low before the next request
                default:
                    state <= tlp_mon_pkg::RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            cfg_data <= sel_value;
    end

endmodule

`default_nettype wire

// ==== design/read_event_tracker.sv ====
/*
 * Read event tracker
 * Accumulates request, completion and outstanding dword counters
 * from the three stream decoders, with per-counter clear
 */

`timescale 1ns/1ns
`default_nettype none

`include "tlp_mon_defs.svh"

module read_event_tracker
(
    input  wire                              clk,
    input  wire                              reset_n,

    input  wire  [`DWORD_CNT_W-1:0]          tx_dwords,
    input  wire  [`DWORD_CNT_W-1:0]          tx_b_dwords,
    input  wire  [`DWORD_CNT_W-1:0]          rx_dwords,
    input  wire                              tx_event,
    input  wire                              tx_b_event,
    input  wire                              rx_event,

    input  wire                              clear,
    input  wire  tlp_mon_pkg::counter_sel_t  clear_sel,

    output logic [`CNT_W-1:0]                req_dwords,
    output logic [`CNT_W-1:0]                rsp_dwords,
    output logic [`CNT_W-1:0]                outstanding,
    output logic [`CNT_W-1:0]                req_tlps,
    output logic [`CNT_W-1:0]                cpl_tlps
);

    localparam int DW = `DWORD_CNT_W;
    localparam int CW = `CNT_W;

    logic [DW-1:0] req_inc;
    logic [1:0]    req_evt_inc;

    logic clr_req_dwords;
    logic clr_rsp_dwords;
    logic clr_outstanding;
    logic clr_req_tlps;
    logic clr_cpl_tlps;

    // A cleared counter restarts from zero, this cycle's increment still lands
    function automatic logic [CW-1:0] base_value(
        input logic [CW-1:0] cur,
        input logic          hit
    );
        return hit ? '0 : cur;
    endfunction

    // Both request pipes may carry an MRd header in the same cycle
    assign req_inc     = tx_dwords + tx_b_dwords;
    assign req_evt_inc = {1'b0, tx_event} + {1'b0, tx_b_event};

    assign clr_req_dwords  = clear && (clear_sel == tlp_mon_pkg::SEL_REQ_DWORDS);
    assign clr_rsp_dwords  = clear && (clear_sel == tlp_mon_pkg::SEL_RSP_DWORDS);
    assign clr_outstanding = clear && (clear_sel == tlp_mon_pkg::SEL_OUTSTANDING);
    assign clr_req_tlps    = clear && (clear_sel == tlp_mon_pkg::SEL_REQ_TLPS);
    assign clr_cpl_tlps    = clear && (clear_sel == tlp_mon_pkg::SEL_CPL_TLPS);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            req_dwords  <= '0;
            rsp_dwords  <= '0;
            outstanding <= '0;
            req_tlps    <= '0;
            cpl_tlps    <= '0;
        end
        else
        begin
            req_dwords <= base_value(req_dwords, clr_req_dwords) + CW'(req_inc);
            rsp_dwords <= base_value(rsp_dwords, clr_rsp_dwords) + CW'(rx_dwords);

            // Wraps modulo 2^32 when returns run ahead of a clear
            outstanding <= base_value(outstanding, clr_outstanding)
                           + CW'(req_inc) - CW'(rx_dwords);

            req_tlps <= base_value(req_tlps, clr_req_tlps) + CW'(req_evt_inc);
            cpl_tlps <= base_value(cpl_tlps, clr_cpl_tlps) + CW'(rx_event);
        end
    end

endmodule

`default_nettype wire

// ==== design/tlp_hdr_decode.sv ====
/*
 * Per-stream TLP header decoder
 * Tracks start of packet, classifies the header and registers
 * the read dword count and a one-cycle event for counted TLPs
 */

`timescale 1ns/1ns
`default_nettype none

`include "tlp_mon_defs.svh"

module tlp_hdr_decode
#(
    parameter int IS_COMPLETION = 0
)
(
    input  wire                      clk,
    input  wire                      reset_n,

    input  wire                      en,
    input  wire  [`TLP_DATA_W-1:0]   data,
    input  wire                      tlast,

    output logic [`DWORD_CNT_W-1:0]  rd_dwords,
    output logic                     tlp_event
);

    localparam int DW    = `DWORD_CNT_W;
    localparam int LEN_W = `TLP_LEN_W;

    logic                     sop;
    logic                     hdr_beat;
    tlp_mon_pkg::tlp_kind_t   kind;
    logic [LEN_W-1:0]         len_field;
    logic [DW-1:0]            len_dwords;
    logic                     counted;
    logic                     has_data;

    // Next enabled beat starts a packet when this one was the last
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            sop <= 1'b1;
        else if (en)
            sop <= tlast;
    end

    assign hdr_beat  = en && sop;
    assign kind      = tlp_mon_pkg::classify_fmt_type(
                           data[`TLP_FMT_TYPE_MSB:`TLP_FMT_TYPE_LSB]);
    assign len_field = data[`TLP_LEN_LSB +: LEN_W];

    // Zero length encodes the maximum of 1024 dwords
    assign len_dwords = (len_field == '0) ? DW'(1 << LEN_W) : DW'(len_field);

    always_comb
    begin
        if (IS_COMPLETION != 0)
        begin
            // Both completion flavours are events, only CplD carries data
            counted  = (kind == tlp_mon_pkg::TLP_CPL) || (kind == tlp_mon_pkg::TLP_CPLD);
            has_data = (kind == tlp_mon_pkg::TLP_CPLD);
        end
        else
        begin
            counted  = (kind == tlp_mon_pkg::TLP_MRD);
            has_data = counted;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            tlp_event <= 1'b0;
            rd_dwords <= '0;
        end
        else
        begin
            tlp_event <= hdr_beat && counted;
            rd_dwords <= (hdr_beat && has_data) ? len_dwords : '0;
        end
    end

endmodule

`default_nettype wire

// ==== design/tlp_mon_pkg.sv ====
/*
 * TLP read monitor types
 * TLP kinds, counter selects, readout opcodes, readout FSM states
 */

`default_nettype none

package tlp_mon_pkg;

    typedef enum logic [2:0] {
        TLP_MRD,
        TLP_MWR,
        TLP_CPL,
        TLP_CPLD,
        TLP_OTHER
    } tlp_kind_t;

    typedef enum logic [2:0] {
        SEL_REQ_DWORDS,
        SEL_RSP_DWORDS,
        SEL_OUTSTANDING,
        SEL_REQ_TLPS,
        SEL_CPL_TLPS
    } counter_sel_t;

    typedef enum logic {
        OP_READ,
        OP_READ_CLEAR
    } readout_op_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ACK,
        RD_WAIT_DROP
    } readout_state_t;

    // Map a header fmt_type byte to the kinds the monitor cares about
    function automatic tlp_kind_t classify_fmt_type(input logic [7:0] fmt_type);
        case (fmt_type)
            8'h00, 8'h20: return TLP_MRD;   // 3DW and 4DW reads
            8'h40, 8'h60: return TLP_MWR;
            8'h0A:        return TLP_CPL;
            8'h4A:        return TLP_CPLD;
            default:      return TLP_OTHER;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== design/tlp_mon_defs.svh ====
/*
 * TLP read monitor widths and header field positions
 * Shared by the decoders, the event tracker and the readout port
 */

`ifndef TLP_MON_DEFS_SVH
`define TLP_MON_DEFS_SVH

// Stream data vector width
`define TLP_DATA_W 256

// Header length field, a value of 0 means 1024 dwords
`define TLP_LEN_W 10

// Per-cycle dword sum, room for two 1024-dword requests
`define DWORD_CNT_W 14

// Event counter width
`define CNT_W 32

// Header DW0 positions within the header beat
`define TLP_FMT_TYPE_MSB 31
`define TLP_FMT_TYPE_LSB 24
`define TLP_LEN_LSB 0

`endif
